// File: src.f
hdl/corePkg.sv
hdl/isaPkg.sv
hdl/execIf.sv
hdl/instrQueue.sv
hdl/issueCtrl.sv
hdl/regFile.sv
hdl/intAlu.sv
hdl/intMul.sv
hdl/reorderBuffer.sv
hdl/scalarCore.sv
tb/tbScalarCore.sv

// File: Bender.yml
package:
  name: scalarCore

sources:
  - hdl/corePkg.sv
  - hdl/isaPkg.sv
  - hdl/execIf.sv
  - hdl/instrQueue.sv
  - hdl/issueCtrl.sv
  - hdl/regFile.sv
  - hdl/intAlu.sv
  - hdl/intMul.sv
  - hdl/reorderBuffer.sv
  - hdl/scalarCore.sv
  - target: test
    files:
      - tb/tbScalarCore.sv

// File: tb/tbScalarCore.sv
// Self-checking testbench for scalarCore.
// A table of instructions and expected commits is pushed into the core under
// upstream credits. Commits are compared in order against the table. Commit
// credits are held back at first, then returned after random delays.

`timescale 1ns/10ps
`default_nettype none

module tbScalarCore;

	localparam int QueueDepth    = 4;
	localparam int RobDepth      = 8;
	localparam int CommitCredits = 4;
	localparam int NumRows       = 18;
	localparam int WaitLimit     = 1000;	// Cycles per wait loop
	localparam int StallLimit    = 300;	// Cycles without upstream progress
	localparam int HoldCycles    = 24;	// Window with commit credits withheld

	logic            clock;
	logic            rstN;
	logic            instrValid;
	isaPkg::instrT   instr;
	logic            commitCredit;
	logic            creditReturn;
	logic            commitValid;
	corePkg::regIdxT commitDst;
	corePkg::dataT   commitData;

	// Stimulus and expected commits
	logic [31:0]     instrTab [NumRows];
	corePkg::regIdxT dstTab   [NumRows];
	corePkg::dataT   dataTab  [NumRows];
	int              rowCount;

	integer seed;
	int     errorCount;
	int     timeoutCount;
	int     sentCount;
	int     returnCount;
	int     maxOutstanding;
	int     commitIdx;
	logic   creditsOn;	// Commit credits are returned only when set
	logic   upDone;

	scalarCore #(
		.QueueDepth(QueueDepth),
		.RobDepth(RobDepth),
		.CommitCredits(CommitCredits)
	) scalarCore_i (
		.clock, .rstN, .instrValid, .instr, .commitCredit,
		.creditReturn, .commitValid, .commitDst, .commitData
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	//////////////////////////////////////////////////
	// Table
	//////////////////////////////////////////////////
	task automatic addRow(input logic [31:0] word, input logic [3:0] expDst,
		input logic [31:0] expData);
		instrTab[rowCount] = word;
		dstTab[rowCount]   = expDst;
		dataTab[rowCount]  = expData;
		rowCount++;
	endtask

	task automatic buildTable();
		rowCount = 0;
		// Word nibbles are opcode, dst, src1, src2, then the 16-bit immediate
		addRow(32'h6100_8001, 4'h1, 32'hffff_8001);	// LDI sign-extends
		addRow(32'h6200_1234, 4'h2, 32'h0000_1234);
		addRow(32'h6300_00ff, 4'h3, 32'h0000_00ff);
		addRow(32'h0412_0000, 4'h4, 32'hffff_9235);	// ADD r1 r2
		addRow(32'h1523_0000, 4'h5, 32'h0000_1135);	// SUB r2 r3
		addRow(32'h2613_0000, 4'h6, 32'h0000_0001);	// AND r1 r3
		addRow(32'h3723_0000, 4'h7, 32'h0000_12ff);	// OR r2 r3
		addRow(32'h4813_0000, 4'h8, 32'hffff_80fe);	// XOR r1 r3
		addRow(32'h6900_0024, 4'h9, 32'h0000_0024);	// Shift 36, low 5 bits give 4
		addRow(32'h5a39_0000, 4'ha, 32'h0000_0ff0);	// SHL r3 by r9
		addRow(32'h7b11_0000, 4'hb, 32'h3fff_0001);	// MUL, low word of product
		addRow(32'h0c23_0000, 4'hc, 32'h0000_1333);	// Independent ADD finishes first
		// RAW chain
		addRow(32'h0dc3_0000, 4'hd, 32'h0000_1432);
		addRow(32'h1ed2_0000, 4'he, 32'h0000_01fe);
		addRow(32'h7fe3_0000, 4'hf, 32'h0001_fc02);
		addRow(32'h41fe_0000, 4'h1, 32'h0001_fdfc);
		addRow(32'h5219_0000, 4'h2, 32'h001f_dfc0);
		addRow(32'hf312_0000, 4'h3, 32'h0000_0000);	// Reserved opcode writes zero
	endtask

	//////////////////////////////////////////////////
	// Upstream source and commit monitor
	//////////////////////////////////////////////////
	task automatic sendInstructions();
		int credits;
		int stall;
		credits = QueueDepth;
		stall   = 0;
		while (!upDone) begin
			@(negedge clock);
			if (creditReturn) begin
				returnCount++;
				credits++;
				stall = 0;
				if (returnCount > sentCount) begin
					$display("More upstream credits returned than instructions sent");
					errorCount++;
				end
			end
			if (sentCount < NumRows && credits > 0) begin
				instrValid = 1'b1;
				instr      = isaPkg::instrT'(instrTab[sentCount]);
				sentCount++;
				credits--;
				stall = 0;
				if (sentCount - returnCount > maxOutstanding)
					maxOutstanding = sentCount - returnCount;
			end else begin
				instrValid = 1'b0;
				stall++;
			end
			if (sentCount == NumRows && returnCount == sentCount) begin
				upDone = 1'b1;
			end else if (stall > StallLimit) begin
				$display("Timeout: no upstream progress for %0d cycles", StallLimit);
				timeoutCount++;
				upDone = 1'b1;
			end
		end
	endtask

	task automatic checkCommit();
		if (commitIdx >= NumRows) begin
			$display("Commit seen after the last table row");
			errorCount++;
		end else begin
			if (commitDst !== dstTab[commitIdx]) begin
				$display("FAIL row %0d commitDst = 0x%h, expected 0x%h",
					commitIdx, commitDst, dstTab[commitIdx]);
				errorCount++;
			end
			if (commitData !== dataTab[commitIdx]) begin
				$display("FAIL row %0d commitData = 0x%h, expected 0x%h",
					commitIdx, commitData, dataTab[commitIdx]);
				errorCount++;
			end
		end
		commitIdx++;
	endtask

	task automatic watchCommits();
		int pending;
		int delay;
		pending = 0;
		delay   = 0;
		forever begin
			@(negedge clock);
			if (commitValid) begin
				checkCommit();
				pending++;	// One credit owed per commit
			end
			commitCredit = 1'b0;
			if (creditsOn && pending > 0) begin
				if (delay == 0) begin
					commitCredit = 1'b1;
					pending--;
					delay = $unsigned($random(seed)) % 4;
				end else begin
					delay--;
				end
			end
		end
	endtask

	task automatic waitForCommits(input int target, output bit reached);
		int cycles;
		cycles = 0;
		while (commitIdx < target && cycles < WaitLimit) begin
			@(posedge clock);
			cycles++;
		end
		reached = (commitIdx >= target);
		if (!reached) begin
			$display("Timeout: %0d of %0d commits seen", commitIdx, target);
			timeoutCount++;
		end
	endtask

	task automatic waitForUpstream(output bit reached);
		int cycles;
		cycles = 0;
		while (!upDone && cycles < WaitLimit) begin
			@(posedge clock);
			cycles++;
		end
		reached = upDone;
		if (!reached) begin
			$display("Timeout: upstream source did not finish");
			timeoutCount++;
		end
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////
	initial begin : mainSeq
		bit reached;
		rstN           = 1'b0;
		instrValid     = 1'b0;
		instr          = '0;
		commitCredit   = 1'b0;
		creditsOn      = 1'b0;
		upDone         = 1'b0;
		seed           = 32'hca46_ff0b;
		errorCount     = 0;
		timeoutCount   = 0;
		sentCount      = 0;
		returnCount    = 0;
		maxOutstanding = 0;
		commitIdx      = 0;
		buildTable();
		repeat (4) @(negedge clock);
		rstN = 1'b1;

		fork
			sendInstructions();
			watchCommits();
		join_none

		// Only the initial commit credits are usable here
		waitForCommits(CommitCredits, reached);
		if (reached) begin
			repeat (HoldCycles) @(posedge clock);
			if (commitIdx > CommitCredits) begin
				$display("FAIL commitCount = 0x%h with credits withheld, expected 0x%h",
					commitIdx, CommitCredits);
				errorCount++;
			end
			creditsOn = 1'b1;
			waitForCommits(NumRows, reached);
		end
		if (reached)
			waitForUpstream(reached);
		if (reached) begin
			if (returnCount != sentCount) begin
				$display("FAIL creditReturn count = 0x%h, expected 0x%h",
					returnCount, sentCount);
				errorCount++;
			end
			// Stalled issue fills the queue, so every upstream credit gets used
			if (maxOutstanding != QueueDepth) begin
				$display("FAIL outstanding = 0x%h, expected 0x%h",
					maxOutstanding, QueueDepth);
				errorCount++;
			end
		end
		repeat (8) @(posedge clock);	// Room for a stray commit to show

		$display("Checked %0d commits, %0d errors, %0d timeouts",
			commitIdx, errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0 && commitIdx == NumRows)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/scalarCore.sv
// Top level of the scalar back-end. Instructions enter under upstream credits,
// issue to the ALU or multiplier, and commit in order under downstream
// credits. Every commit also appears on commitValid, commitDst and commitData.

`timescale 1ns/10ps
`default_nettype none

module scalarCore #(
	parameter int QueueDepth    = 4,
	parameter int RobDepth      = 8,
	parameter int CommitCredits = 4
) (
	input  wire                clock,
	input  wire                rstN,
	input  wire                instrValid,
	input  wire isaPkg::instrT instr,
	input  wire                commitCredit,
	output logic               creditReturn,
	output logic               commitValid,
	output corePkg::regIdxT    commitDst,
	output corePkg::dataT      commitData
);
	localparam int NoW = $clog2(RobDepth);

	isaPkg::instrT   head;
	logic            headValid, pop;
	corePkg::regIdxT rdIdx1, rdIdx2;
	corePkg::dataT   rdData1, rdData2;

	// Completion paths into the reorder buffer
	logic            aluDoneValid, mulDoneValid;
	logic [NoW-1:0]  aluDoneNo, mulDoneNo;
	corePkg::dataT   aluDoneData, mulDoneData;

	execIf #(.RobDepth(RobDepth)) aluIssue ();
	execIf #(.RobDepth(RobDepth)) mulIssue ();
	robIf  #(.RobDepth(RobDepth)) robBus ();

	//////////////////////////////////////////////////
	// Front end
	//////////////////////////////////////////////////
	instrQueue #(.Depth(QueueDepth)) instrQueue_i (
		.clock, .rstN,
		.pushValid(instrValid), .pushInstr(instr), .pop,
		.head, .headValid, .creditReturn
	);

	issueCtrl #(.RobDepth(RobDepth), .CommitCredits(CommitCredits)) issueCtrl_i (
		.clock, .rstN, .head, .headValid, .rdData1, .rdData2, .commitCredit,
		.pop, .rdIdx1, .rdIdx2,
		.aluIssue(aluIssue.ctrl), .mulIssue(mulIssue.ctrl), .rob(robBus.ctrl)
	);

	regFile #(.DataWidth(corePkg::DataWidth), .NumRegs(corePkg::NumRegs)) regFile_i (
		.clock, .rstN, .rdIdx1, .rdIdx2,
		.we(commitValid), .wrIdx(commitDst), .wrData(commitData),	// Commit write
		.rdData1, .rdData2
	);

	//////////////////////////////////////////////////
	// Execution pipes and commit
	//////////////////////////////////////////////////
	intAlu #(.RobDepth(RobDepth)) intAlu_i (
		.clock, .rstN, .issue(aluIssue.unit),
		.doneValid(aluDoneValid), .doneNo(aluDoneNo), .doneData(aluDoneData)
	);

	intMul #(.RobDepth(RobDepth)) intMul_i (
		.clock, .rstN, .issue(mulIssue.unit),
		.doneValid(mulDoneValid), .doneNo(mulDoneNo), .doneData(mulDoneData)
	);

	reorderBuffer #(.RobDepth(RobDepth)) reorderBuffer_i (
		.clock, .rstN, .ctrl(robBus.rob),
		.aluValid(aluDoneValid), .aluNo(aluDoneNo), .aluData(aluDoneData),
		.mulValid(mulDoneValid), .mulNo(mulDoneNo), .mulData(mulDoneData),
		.commitValid, .commitDst, .commitData
	);

endmodule

`default_nettype wire

// File: hdl/reorderBuffer.sv
// Reorder buffer indexed by issue number. Entries are allocated in issue order,
// completed out of order by the ALU and multiplier ports, and committed in
// order. The head commits the cycle after its done flag is set; the commit
// drives the register-file write and the top-level commit outputs.

`timescale 1ns/10ps
`default_nettype none

module reorderBuffer #(
	parameter int RobDepth = 8
) (
	input  wire                              clock,
	input  wire                              rstN,
	robIf.rob                                ctrl,
	input  wire                              aluValid,
	input  wire [$clog2(RobDepth)-1:0]       aluNo,
	input  wire corePkg::dataT               aluData,
	input  wire                              mulValid,
	input  wire [$clog2(RobDepth)-1:0]       mulNo,
	input  wire corePkg::dataT               mulData,
	output logic                             commitValid,
	output corePkg::regIdxT                  commitDst,
	output corePkg::dataT                    commitData
);
	localparam int IdxW = $clog2(RobDepth);

	// Pointers carry one extra wrap bit
	logic [IdxW:0]     headPtr, tailPtr;
	logic [IdxW-1:0]   headIdx;
	logic [RobDepth-1:0] done;
	corePkg::regIdxT   dstMem  [RobDepth];
	corePkg::dataT     dataMem [RobDepth];

	assign headIdx     = headPtr[IdxW-1:0];
	assign commitValid = done[headIdx];	// Done is cleared at commit
	assign commitDst   = dstMem[headIdx];
	assign commitData  = dataMem[headIdx];

	assign ctrl.commitValid = commitValid;
	assign ctrl.commitDst   = commitDst;
	assign ctrl.full = (headPtr[IdxW] != tailPtr[IdxW]) &&
		(headPtr[IdxW-1:0] == tailPtr[IdxW-1:0]);

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			headPtr <= '0;
			tailPtr <= '0;
			done    <= '0;
		end else begin
			if (ctrl.allocValid)
				tailPtr <= tailPtr + 1'b1;
			if (commitValid) begin
				done[headIdx] <= 1'b0;
				headPtr       <= headPtr + 1'b1;
			end
			if (aluValid) done[aluNo] <= 1'b1;
			if (mulValid) done[mulNo] <= 1'b1;
		end
	end

	// Entry payload
	always_ff @(posedge clock) begin
		if (ctrl.allocValid) dstMem[ctrl.allocNo] <= ctrl.allocDst;
		if (aluValid)        dataMem[aluNo]       <= aluData;
		if (mulValid)        dataMem[mulNo]       <= mulData;
	end

endmodule

`default_nettype wire

// File: hdl/intMul.sv
// Pipelined multiplier. Operands are registered, then the low word of the
// product moves down the remaining stages. Valid and issue number travel
// alongside, so one multiply can enter every cycle.

`timescale 1ns/10ps
`default_nettype none

module intMul #(
	parameter int RobDepth = 8
) (
	input  wire                         clock,
	input  wire                         rstN,
	execIf.unit                         issue,
	output logic                        doneValid,
	output logic [$clog2(RobDepth)-1:0] doneNo,
	output corePkg::dataT               doneData
);
	localparam int Stages = corePkg::MulStages;

	logic [Stages-1:0]           vPipe;
	logic [$clog2(RobDepth)-1:0] noPipe [Stages];
	corePkg::dataT               aReg, bReg;		// Stage 1
	corePkg::dataT               prodPipe [Stages-1];	// Later stages

	assign doneValid = vPipe[Stages-1];
	assign doneNo    = noPipe[Stages-1];
	assign doneData  = prodPipe[Stages-2];

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN)
			vPipe <= '0;
		else
			vPipe <= {vPipe[Stages-2:0], issue.valid};
	end

	always_ff @(posedge clock) begin
		aReg        <= issue.opA;
		bReg        <= issue.opB;
		noPipe[0]   <= issue.issueNo;
		prodPipe[0] <= aReg * bReg;	// Low 32 bits kept
		for (int s = 1; s < Stages; s++)
			noPipe[s] <= noPipe[s-1];
		for (int s = 1; s < Stages - 1; s++)
			prodPipe[s] <= prodPipe[s-1];
	end

endmodule

`default_nettype wire

// File: hdl/intAlu.sv
// Single-stage integer ALU pipe. Result and issue number appear on the
// completion port one cycle after issue.

`timescale 1ns/10ps
`default_nettype none

module intAlu #(
	parameter int RobDepth = 8
) (
	input  wire                         clock,
	input  wire                         rstN,
	execIf.unit                         issue,
	output logic                        doneValid,
	output logic [$clog2(RobDepth)-1:0] doneNo,
	output corePkg::dataT               doneData
);
	corePkg::dataT result;

	always_comb begin
		case (issue.op)
			isaPkg::ADD: result = issue.opA + issue.opB;
			isaPkg::SUB: result = issue.opA - issue.opB;
			isaPkg::AND: result = issue.opA & issue.opB;
			isaPkg::OR:  result = issue.opA | issue.opB;
			isaPkg::XOR: result = issue.opA ^ issue.opB;
			isaPkg::SHL: result = issue.opA << issue.opB[4:0];	// 5 shift bits only
			isaPkg::LDI: result = issue.opA;
			default:     result = '0;
		endcase
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN)
			doneValid <= 1'b0;
		else
			doneValid <= issue.valid;
	end

	always_ff @(posedge clock) begin
		doneNo   <= issue.issueNo;
		doneData <= result;
	end

endmodule

`default_nettype wire

// File: hdl/regFile.sv
// Architectural register file, one bank with two asynchronous read ports
// and one synchronous write port fed by the commit stage.

`timescale 1ns/10ps
`default_nettype none

module regFile #(
	parameter int DataWidth = 32,
	parameter int NumRegs   = 16
) (
	input  wire                         clock,
	input  wire                         rstN,
	input  wire [$clog2(NumRegs)-1:0]   rdIdx1,
	input  wire [$clog2(NumRegs)-1:0]   rdIdx2,
	input  wire                         we,
	input  wire [$clog2(NumRegs)-1:0]   wrIdx,
	input  wire [DataWidth-1:0]         wrData,
	output logic [DataWidth-1:0]        rdData1,
	output logic [DataWidth-1:0]        rdData2
);
	logic [DataWidth-1:0] regs [NumRegs];

	assign rdData1 = regs[rdIdx1];
	assign rdData2 = regs[rdIdx2];

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < NumRegs; i++)
				regs[i] <= '0;	// Registers start at zero
		end else if (we) begin
			regs[wrIdx] <= wrData;
		end
	end

endmodule

`default_nettype wire

// File: hdl/issueCtrl.sv
// Decode and issue stage. Checks the head instruction against the busy-register
// scoreboard, the reorder-buffer full flag and the commit credits, then issues
// one instruction per cycle to the ALU or the multiplier.
// Operands come combinationally from the register file in the issue cycle.

`timescale 1ns/10ps
`default_nettype none

module issueCtrl #(
	parameter int RobDepth      = 8,
	parameter int CommitCredits = 4
) (
	input  wire                  clock,
	input  wire                  rstN,
	input  wire isaPkg::instrT   head,
	input  wire                  headValid,
	input  wire corePkg::dataT   rdData1,
	input  wire corePkg::dataT   rdData2,
	input  wire                  commitCredit,
	output logic                 pop,
	output corePkg::regIdxT      rdIdx1,
	output corePkg::regIdxT      rdIdx2,
	execIf.ctrl                  aluIssue,
	execIf.ctrl                  mulIssue,
	robIf.ctrl                   rob
);
	localparam int CreditW = $clog2(CommitCredits + 1);

	logic [corePkg::NumRegs-1:0] busy;	// Scoreboard, one bit per register
	logic [$clog2(RobDepth)-1:0] issueNo;
	logic [CreditW-1:0]          credits;
	logic                        isMul, isLdi, hazard, canIssue;
	corePkg::dataT               opA;

	//////////////////////////////////////////////////
	// Decode and hazard check
	//////////////////////////////////////////////////
	assign isMul  = (head.opcode == isaPkg::MUL);
	assign isLdi  = (head.opcode == isaPkg::LDI);
	assign rdIdx1 = head.src1;
	assign rdIdx2 = head.src2;

	// LDI reads no source registers
	assign hazard = busy[head.dst] |
		(!isLdi && (busy[head.src1] || busy[head.src2]));

	assign canIssue = headValid && !hazard && !rob.full && (credits != '0);
	assign pop      = canIssue;

	assign opA = isLdi ? {{(corePkg::DataWidth - 16){head.imm[15]}}, head.imm} : rdData1;

	//////////////////////////////////////////////////
	// Issue to the pipes and the reorder buffer
	//////////////////////////////////////////////////
	assign aluIssue.valid   = canIssue && !isMul;
	assign aluIssue.issueNo = issueNo;
	assign aluIssue.op      = head.opcode;
	assign aluIssue.opA     = opA;
	assign aluIssue.opB     = rdData2;

	assign mulIssue.valid   = canIssue && isMul;
	assign mulIssue.issueNo = issueNo;
	assign mulIssue.op      = head.opcode;
	assign mulIssue.opA     = rdData1;
	assign mulIssue.opB     = rdData2;

	assign rob.allocValid = canIssue;
	assign rob.allocNo    = issueNo;
	assign rob.allocDst   = head.dst;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			busy    <= '0;
			issueNo <= '0;
			credits <= CreditW'(CommitCredits);
		end else begin
			if (rob.commitValid)
				busy[rob.commitDst] <= 1'b0;
			if (canIssue) begin
				busy[head.dst] <= 1'b1;
				issueNo        <= issueNo + 1'b1;
			end
			// One credit reserved per issue, one returned per pulse
			if (canIssue && !commitCredit)
				credits <= credits - 1'b1;
			else if (!canIssue && commitCredit)
				credits <= credits + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hdl/instrQueue.sv
// Instruction FIFO at the front of the core.
// The source pushes under credits. Each pop at issue returns one credit
// through creditReturn one cycle later.

`timescale 1ns/10ps
`default_nettype none

module instrQueue #(
	parameter int Depth = 4
) (
	input  wire                clock,
	input  wire                rstN,
	input  wire                pushValid,
	input  wire isaPkg::instrT pushInstr,
	input  wire                pop,
	output isaPkg::instrT      head,
	output logic               headValid,
	output logic               creditReturn
);
	localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;

	isaPkg::instrT          mem [Depth];
	logic [PtrW-1:0]        wrPtr, rdPtr;
	logic [$clog2(Depth+1)-1:0] count;

	assign head      = mem[rdPtr];
	assign headValid = (count != '0);

	always_ff @(posedge clock) begin
		if (pushValid)
			mem[wrPtr] <= pushInstr;
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			wrPtr        <= '0;
			rdPtr        <= '0;
			count        <= '0;
			creditReturn <= 1'b0;
		end else begin
			if (pushValid)
				wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
			count        <= count + pushValid - pop;	// Credits prevent overflow
			creditReturn <= pop;
		end
	end

endmodule

`default_nettype wire

// File: hdl/execIf.sv
// Bundles between the issue controller and the rest of the core.
// execIf carries one issued instruction to an execution pipe.
// robIf carries reorder-buffer allocation, the full flag and commits.

`timescale 1ns/10ps
`default_nettype none

interface execIf #(
	parameter int RobDepth = 8
);
	logic                        valid;		// One cycle per instruction
	logic [$clog2(RobDepth)-1:0] issueNo;
	isaPkg::opcodeT              op;
	corePkg::dataT               opA;
	corePkg::dataT               opB;

	modport ctrl (output valid, issueNo, op, opA, opB);
	modport unit (input valid, issueNo, op, opA, opB);
endinterface

interface robIf #(
	parameter int RobDepth = 8
);
	logic                        allocValid;
	logic [$clog2(RobDepth)-1:0] allocNo;
	corePkg::regIdxT             allocDst;
	logic                        full;
	logic                        commitValid;
	corePkg::regIdxT             commitDst;	// Clears the scoreboard bit

	modport ctrl (
		output allocValid, allocNo, allocDst,
		input  full, commitValid, commitDst
	);
	modport rob (
		input  allocValid, allocNo, allocDst,
		output full, commitValid, commitDst
	);
endinterface

`default_nettype wire

// File: hdl/isaPkg.sv
// Instruction encoding of the scalar core.
// A 32-bit word carries opcode, destination, two sources and a 16-bit immediate.

`default_nettype none

package isaPkg;

	// Opcodes, codes 8 to 15 are reserved and produce zero
	typedef enum logic [3:0] {
		ADD = 4'h0,
		SUB = 4'h1,
		AND = 4'h2,
		OR  = 4'h3,
		XOR = 4'h4,
		SHL = 4'h5,
		LDI = 4'h6,	// Load sign-extended immediate
		MUL = 4'h7
	} opcodeT;

	typedef struct packed {
		opcodeT          opcode;	// [31:28]
		corePkg::regIdxT dst;		// [27:24]
		corePkg::regIdxT src1;		// [23:20]
		corePkg::regIdxT src2;		// [19:16]
		logic [15:0]     imm;		// [15:0]
	} instrT;

endpackage

`default_nettype wire

// File: hdl/corePkg.sv
// Microarchitecture widths and data types shared by the scalar core.
// Modules refer to these by scoped names such as corePkg::dataT.

`default_nettype none

package corePkg;

	//////////////////////////////////////////////////
	// Datapath sizes
	//////////////////////////////////////////////////
	localparam int DataWidth = 32;	// Register and result width
	localparam int NumRegs   = 16;	// Architectural registers
	localparam int MulStages = 3;	// Multiplier pipe depth

	//////////////////////////////////////////////////
	// Common types
	//////////////////////////////////////////////////
	// One register value
	typedef logic [DataWidth-1:0] dataT;

	// Register number
	typedef logic [$clog2(NumRegs)-1:0] regIdxT;

endpackage

`default_nettype wire
